//--- Makefile
# Verilator build for the Wishbone router testbench
VERILATOR ?= verilator
TOP       ?= wb_subsystem_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
src/wb_bus_pkg.sv
src/wb_addr_decode.sv
src/wb_bus_timeout.sv
src/wbs_sub_arbiter.sv
src/wb_reg_slave.sv
src/wb_subsystem_top.sv
tb/wb_subsystem_checker.sv
tb/wb_subsystem_tb.sv

//--- src/wb_addr_decode.sv
`timescale 1ns/1ps

module wb_addr_decode (
  input  logic                   wb_clk_i,
  input  logic                   wb_rst_i,
  input  logic                   cyc_i,
  input  logic                   stb_i,
  input  logic                   we_i,
  input  wb_bus_pkg::wb_sel_t    sel_i,
  input  wb_bus_pkg::wb_addr_t   adr_i,
  input  wb_bus_pkg::wb_data_t   dat_i,
  output logic                   cyc_o,
  output logic                   stb_o,
  output logic                   we_o,
  output wb_bus_pkg::wb_sel_t    sel_o,
  output wb_bus_pkg::wb_data_t   dat_o,
  output wb_bus_pkg::slave_mask_t mask_o,
  output logic                   nomatch_o,
  output wb_bus_pkg::wb_addr_t   local_adr_o
);

  wb_bus_pkg::slave_mask_t match;
  wb_bus_pkg::wb_addr_t    local_adr;

  // all windows compared in parallel
  always_comb begin
    wb_bus_pkg::wb_addr_t off;
    match = '0;
    local_adr = adr_i;
    for (int i = 0; i < wb_bus_pkg::N_SLAVES; i++) begin
      // offset into window i, wraps when below the base
      off = adr_i - wb_bus_pkg::SLAVE_BASE[i];
      match[i] = off <= (wb_bus_pkg::SLAVE_HIGH[i] - wb_bus_pkg::SLAVE_BASE[i]);
      if (match[i]) begin
        local_adr = off;
      end
    end
  end

  // control side of the stage
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      cyc_o     <= 1'b0;
      stb_o     <= 1'b0;
      mask_o    <= '0;
      nomatch_o <= 1'b0;
    end else begin
      cyc_o     <= cyc_i;
      stb_o     <= stb_i;
      mask_o    <= match;
      nomatch_o <= ~|match;
    end
  end

  // payload follows the control by the same cycle
  always_ff @(posedge wb_clk_i) begin
    we_o        <= we_i;
    sel_o       <= sel_i;
    dat_o       <= dat_i;
    local_adr_o <= local_adr;
  end

  // windows must never overlap
  a_mask_onehot : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $onehot0(mask_o));

endmodule

//--- src/wb_bus_pkg.sv
package wb_bus_pkg;

  // address windows behind the router, the last one is reserved
  localparam int N_SLAVES = 4;
  // register banks actually fitted, windows 0 to 2
  localparam int N_DEVICES = 3;

  // watchdog limit in cycles spent waiting on a slave
  localparam int TIMEOUT_CYCLES = 12;
  localparam int TIMER_W = $clog2(TIMEOUT_CYCLES);

  // register bank depth and word index width
  localparam int REG_WORDS = 64;
  localparam int REG_IDX_W = $clog2(REG_WORDS);

  // wide enough for the slowest bank
  localparam int WAIT_CNT_W = 4;

  typedef logic [31:0] wb_addr_t;
  typedef logic [31:0] wb_data_t;
  typedef logic [3:0] wb_sel_t;
  typedef logic [N_SLAVES-1:0] slave_mask_t;
  typedef logic [TIMER_W-1:0] timer_cnt_t;
  typedef logic [WAIT_CNT_W-1:0] wait_cnt_t;

  // last count value before expiry
  localparam timer_cnt_t TIMER_LAST = timer_cnt_t'(TIMEOUT_CYCLES - 1);

  // inclusive window bounds
  localparam wb_addr_t SLAVE_BASE [N_SLAVES] = '{
    32'h0000_0000, 32'h0000_1000, 32'h0000_2000, 32'h0000_3000
  };
  localparam wb_addr_t SLAVE_HIGH [N_SLAVES] = '{
    32'h0000_00FF, 32'h0000_10FF, 32'h0000_20FF, 32'h0000_30FF
  };

  // ack delay of each fitted bank
  localparam int SLAVE_WAIT [N_DEVICES] = '{0, 2, 5};

  // dispatch controller states
  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    DRAIN
  } arb_state_t;

endpackage

//--- src/wb_bus_timeout.sv
`timescale 1ns/1ps

module wb_bus_timeout (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic enable_i,
  output logic expired_o
);

  wb_bus_pkg::timer_cnt_t count;

  // counts enabled cycles and holds at the limit
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      count <= '0;
    end else if (!enable_i) begin
      count <= '0;
    end else if (count != wb_bus_pkg::TIMER_LAST) begin
      count <= count + 1'b1;
    end
  end

  // high on the limit-th cycle of a continuous enable
  assign expired_o = enable_i && (count == wb_bus_pkg::TIMER_LAST);

  // no expiry before a full limit of enabled cycles
  a_expiry_after_limit : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    expired_o |-> $past(enable_i, wb_bus_pkg::TIMEOUT_CYCLES - 1));

endmodule

//--- src/wb_reg_slave.sv
`timescale 1ns/1ps

module wb_reg_slave #(
  parameter int WAIT_STATES = 0
) (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 cyc_i,
  input  logic                 stb_i,
  input  logic                 we_i,
  input  wb_bus_pkg::wb_sel_t  sel_i,
  input  wb_bus_pkg::wb_addr_t adr_i,
  input  wb_bus_pkg::wb_data_t dat_i,
  output logic                 ack_o,
  output wb_bus_pkg::wb_data_t dat_o
);

  wb_bus_pkg::wb_data_t mem [wb_bus_pkg::REG_WORDS];
  wb_bus_pkg::wait_cnt_t wait_cnt;
  logic [wb_bus_pkg::REG_IDX_W-1:0] idx;
  logic req;
  logic done;
  logic fire;

  assign req = cyc_i && stb_i;
  // word index, byte offset bits ignored
  assign idx = adr_i[wb_bus_pkg::REG_IDX_W+1:2];
  // wait states used up and not yet answered
  assign fire = req && !done && (wait_cnt == wb_bus_pkg::wait_cnt_t'(WAIT_STATES));

  // wait counter and ack
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wait_cnt <= '0;
      done     <= 1'b0;
      ack_o    <= 1'b0;
    end else if (!req) begin
      // strobe gone, rearm for the next one
      wait_cnt <= '0;
      done     <= 1'b0;
      ack_o    <= 1'b0;
    end else begin
      ack_o <= fire;
      if (fire) begin
        done <= 1'b1;
      end else if (!done) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  // bank access at ack time
  always_ff @(posedge wb_clk_i) begin
    if (fire) begin
      if (we_i) begin
        for (int b = 0; b < 4; b++) begin
          // only the selected byte lanes
          if (sel_i[b]) begin
            mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
          end
        end
      end
      dat_o <= mem[idx];
    end
  end

  // ack is a single-cycle pulse for a live strobe
  a_ack_pulse : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    ack_o |=> !ack_o);

endmodule

//--- src/wb_subsystem_top.sv
`timescale 1ns/1ps

module wb_subsystem_top (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 wbm_cyc_i,
  input  logic                 wbm_stb_i,
  input  logic                 wbm_we_i,
  input  wb_bus_pkg::wb_sel_t  wbm_sel_i,
  input  wb_bus_pkg::wb_addr_t wbm_adr_i,
  input  wb_bus_pkg::wb_data_t wbm_dat_i,
  output wb_bus_pkg::wb_data_t wbm_dat_o,
  output logic                 wbm_ack_o,
  output logic                 wbm_err_o
);

  // input register stage
  logic cyc_r;
  logic stb_r;
  logic we_r;
  wb_bus_pkg::wb_sel_t  sel_r;
  wb_bus_pkg::wb_addr_t adr_r;
  wb_bus_pkg::wb_data_t dat_r;

  // decode stage outputs
  logic dec_cyc;
  logic dec_stb;
  logic dec_we;
  logic dec_nomatch;
  wb_bus_pkg::wb_sel_t     dec_sel;
  wb_bus_pkg::wb_data_t    dec_dat;
  wb_bus_pkg::wb_addr_t    dec_adr;
  wb_bus_pkg::slave_mask_t dec_mask;

  // watchdog handshake
  logic timer_en;
  logic expired;

  // slave bus
  wb_bus_pkg::slave_mask_t wbs_cyc;
  wb_bus_pkg::slave_mask_t wbs_stb;
  wb_bus_pkg::slave_mask_t wbs_ack;
  wb_bus_pkg::wb_data_t [wb_bus_pkg::N_SLAVES-1:0] wbs_rdat;
  logic wbs_we;
  wb_bus_pkg::wb_sel_t  wbs_sel;
  wb_bus_pkg::wb_addr_t wbs_adr;
  wb_bus_pkg::wb_data_t wbs_wdat;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      cyc_r <= 1'b0;
      stb_r <= 1'b0;
    end else begin
      cyc_r <= wbm_cyc_i;
      stb_r <= wbm_stb_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    we_r  <= wbm_we_i;
    sel_r <= wbm_sel_i;
    adr_r <= wbm_adr_i;
    dat_r <= wbm_dat_i;
  end

  wb_addr_decode u_decode (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .cyc_i       (cyc_r),
    .stb_i       (stb_r),
    .we_i        (we_r),
    .sel_i       (sel_r),
    .adr_i       (adr_r),
    .dat_i       (dat_r),
    .cyc_o       (dec_cyc),
    .stb_o       (dec_stb),
    .we_o        (dec_we),
    .sel_o       (dec_sel),
    .dat_o       (dec_dat),
    .mask_o      (dec_mask),
    .nomatch_o   (dec_nomatch),
    .local_adr_o (dec_adr)
  );

  wb_bus_timeout u_timeout (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .enable_i  (timer_en),
    .expired_o (expired)
  );

  wbs_sub_arbiter u_arbiter (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .req_cyc_i     (dec_cyc),
    .req_stb_i     (dec_stb),
    .req_we_i      (dec_we),
    .req_sel_i     (dec_sel),
    .req_dat_i     (dec_dat),
    .req_mask_i    (dec_mask),
    .req_nomatch_i (dec_nomatch),
    .req_adr_i     (dec_adr),
    .expired_i     (expired),
    .timer_en_o    (timer_en),
    .wbs_ack_i     (wbs_ack),
    .wbs_dat_i     (wbs_rdat),
    .wbs_cyc_o     (wbs_cyc),
    .wbs_stb_o     (wbs_stb),
    .wbs_we_o      (wbs_we),
    .wbs_sel_o     (wbs_sel),
    .wbs_adr_o     (wbs_adr),
    .wbs_dat_o     (wbs_wdat),
    .wbm_ack_o     (wbm_ack_o),
    .wbm_err_o     (wbm_err_o),
    .wbm_dat_o     (wbm_dat_o)
  );

  // one register bank per fitted window
  for (genvar i = 0; i < wb_bus_pkg::N_DEVICES; i++) begin : g_slave
    wb_reg_slave #(
      .WAIT_STATES (wb_bus_pkg::SLAVE_WAIT[i])
    ) u_slave (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .cyc_i    (wbs_cyc[i]),
      .stb_i    (wbs_stb[i]),
      .we_i     (wbs_we),
      .sel_i    (wbs_sel),
      .adr_i    (wbs_adr),
      .dat_i    (wbs_wdat),
      .ack_o    (wbs_ack[i]),
      .dat_o    (wbs_rdat[i])
    );
  end

  // reserved window, nobody home so the watchdog ends the cycle
  assign wbs_ack[wb_bus_pkg::N_SLAVES-1]  = 1'b0;
  assign wbs_rdat[wb_bus_pkg::N_SLAVES-1] = '0;

endmodule

//--- src/wbs_sub_arbiter.sv
`timescale 1ns/1ps

module wbs_sub_arbiter (
  input  logic                                             wb_clk_i,
  input  logic                                             wb_rst_i,
  // decoded request
  input  logic                                             req_cyc_i,
  input  logic                                             req_stb_i,
  input  logic                                             req_we_i,
  input  wb_bus_pkg::wb_sel_t                              req_sel_i,
  input  wb_bus_pkg::wb_data_t                             req_dat_i,
  input  wb_bus_pkg::slave_mask_t                          req_mask_i,
  input  logic                                             req_nomatch_i,
  input  wb_bus_pkg::wb_addr_t                             req_adr_i,
  // watchdog
  input  logic                                             expired_i,
  output logic                                             timer_en_o,
  // slave side
  input  wb_bus_pkg::slave_mask_t                          wbs_ack_i,
  input  wb_bus_pkg::wb_data_t [wb_bus_pkg::N_SLAVES-1:0]  wbs_dat_i,
  output wb_bus_pkg::slave_mask_t                          wbs_cyc_o,
  output wb_bus_pkg::slave_mask_t                          wbs_stb_o,
  output logic                                             wbs_we_o,
  output wb_bus_pkg::wb_sel_t                              wbs_sel_o,
  output wb_bus_pkg::wb_addr_t                             wbs_adr_o,
  output wb_bus_pkg::wb_data_t                             wbs_dat_o,
  // master side
  output logic                                             wbm_ack_o,
  output logic                                             wbm_err_o,
  output wb_bus_pkg::wb_data_t                             wbm_dat_o
);

  wb_bus_pkg::arb_state_t state;
  wb_bus_pkg::slave_mask_t active;
  wb_bus_pkg::slave_mask_t ack_q;
  wb_bus_pkg::wb_data_t [wb_bus_pkg::N_SLAVES-1:0] dat_q;
  wb_bus_pkg::wb_data_t rd_word;
  logic req;
  logic issue;
  logic ack_hit;
  logic err_q;

  assign req = req_cyc_i && req_stb_i;
  // new request that maps to a window
  assign issue = (state == wb_bus_pkg::IDLE) && req && !req_nomatch_i;
  // registered ack from the slave we are waiting on
  assign ack_hit = (state == wb_bus_pkg::WAIT) && |(ack_q & active);
  // watchdog runs only while a slave owes us an answer
  assign timer_en_o = (state == wb_bus_pkg::WAIT);

  // mux read data by the latched one-hot mask
  always_comb begin
    rd_word = '0;
    for (int i = 0; i < wb_bus_pkg::N_SLAVES; i++) begin
      rd_word = rd_word | (dat_q[i] & {32{active[i]}});
    end
  end

  // main FSM
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state     <= wb_bus_pkg::IDLE;
      active    <= '0;
      wbs_cyc_o <= '0;
      wbs_stb_o <= '0;
      err_q     <= 1'b0;
    end else begin
      // err is a single pulse
      err_q <= 1'b0;
      case (state)
        wb_bus_pkg::IDLE: begin
          if (req && req_nomatch_i) begin
            // nothing at that address
            err_q <= 1'b1;
            state <= wb_bus_pkg::DRAIN;
          end else if (issue) begin
            active    <= req_mask_i;
            wbs_cyc_o <= req_mask_i;
            wbs_stb_o <= req_mask_i;
            state     <= wb_bus_pkg::WAIT;
          end
        end
        wb_bus_pkg::WAIT: begin
          if (ack_hit) begin
            wbs_cyc_o <= '0;
            wbs_stb_o <= '0;
            state     <= wb_bus_pkg::DRAIN;
          end else if (expired_i) begin
            // slave never answered, drop the cycle
            wbs_cyc_o <= '0;
            wbs_stb_o <= '0;
            err_q     <= 1'b1;
            state     <= wb_bus_pkg::DRAIN;
          end
        end
        wb_bus_pkg::DRAIN: begin
          // stale copy of the finished request still in the pipe
          if (!req) begin
            state <= wb_bus_pkg::IDLE;
          end
        end
        default: begin
          state <= wb_bus_pkg::IDLE;
        end
      endcase
    end
  end

  // shared slave payload, latched at issue
  always_ff @(posedge wb_clk_i) begin
    if (issue) begin
      wbs_we_o  <= req_we_i;
      wbs_sel_o <= req_sel_i;
      wbs_adr_o <= req_adr_i;
      wbs_dat_o <= req_dat_i;
    end
  end

  // ack return and response output registers
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q     <= '0;
      wbm_ack_o <= 1'b0;
      wbm_err_o <= 1'b0;
    end else begin
      ack_q     <= wbs_ack_i;
      wbm_ack_o <= ack_hit;
      wbm_err_o <= err_q;
    end
  end

  // read data path, no reset needed on the words
  always_ff @(posedge wb_clk_i) begin
    dat_q <= wbs_dat_i;
    if (ack_hit) begin
      wbm_dat_o <= rd_word;
    end
  end

  // one kind of response per request
  a_ack_err_excl : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wbm_ack_o && wbm_err_o));

  // strobes live exactly as long as WAIT
  a_stb_only_wait : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (state != wb_bus_pkg::WAIT) |-> (wbs_stb_o == '0));

endmodule

//--- tb/wb_subsystem_checker.sv
`timescale 1ns/1ps

module wb_subsystem_checker (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 cyc_i,
  input  logic                 stb_i,
  input  logic                 we_i,
  input  wb_bus_pkg::wb_sel_t  sel_i,
  input  wb_bus_pkg::wb_addr_t adr_i,
  input  wb_bus_pkg::wb_data_t dat_i,
  input  logic [2:0]           test_id_i,
  input  logic                 done_i,
  input  logic                 ack_i,
  input  logic                 err_i,
  input  wb_bus_pkg::wb_data_t rdat_i,
  output int                   errors_o
);

  // expected response kinds
  localparam int RESP_ACK = 0;
  localparam int RESP_NOMATCH = 1;
  localparam int RESP_TIMEOUT = 2;

  // shadow of every fitted bank
  wb_bus_pkg::wb_data_t shadow [wb_bus_pkg::N_DEVICES][wb_bus_pkg::REG_WORDS];
  logic pending = 1'b0;
  logic reported = 1'b0;
  int lat;
  int exp_kind;
  wb_bus_pkg::wb_data_t exp_data;
  // request under way
  logic req_we;
  wb_bus_pkg::wb_sel_t  req_sel;
  wb_bus_pkg::wb_addr_t req_adr;
  wb_bus_pkg::wb_data_t req_dat;
  logic [2:0] req_test;
  int n_req = 0;
  int n_resp = 0;
  int value_errs = 0;
  int proto_errs = 0;

  assign errors_o = value_errs + proto_errs;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1: return "full_word";
      3'd2: return "byte_select";
      3'd3: return "unmapped";
      3'd4: return "reserved";
      default: return "random_mix";
    endcase
  endfunction

  // window holding adr or -1 when none
  function automatic int window_of(input wb_bus_pkg::wb_addr_t adr);
    int win;
    win = -1;
    for (int i = 0; i < wb_bus_pkg::N_SLAVES; i++) begin
      if (adr >= wb_bus_pkg::SLAVE_BASE[i] && adr <= wb_bus_pkg::SLAVE_HIGH[i]) begin
        win = i;
      end
    end
    return win;
  endfunction

  // word index inside the window
  function automatic logic [5:0] word_of(input wb_bus_pkg::wb_addr_t adr, input int win);
    wb_bus_pkg::wb_addr_t off;
    off = adr - wb_bus_pkg::SLAVE_BASE[win];
    return off[7:2];
  endfunction

  // selected lanes from the write and old bytes elsewhere
  function automatic wb_bus_pkg::wb_data_t merge_bytes(input wb_bus_pkg::wb_data_t old,
      input wb_bus_pkg::wb_data_t wdat, input wb_bus_pkg::wb_sel_t sel);
    wb_bus_pkg::wb_data_t m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = sel[b] ? wdat[8*b +: 8] : old[8*b +: 8];
    end
    return m;
  endfunction

  // reference outcome of one request from the map and the shadow
  function automatic int expect_response(input wb_bus_pkg::wb_addr_t adr,
                                         output wb_bus_pkg::wb_data_t data);
    int win;
    win = window_of(adr);
    data = '0;
    if (win < 0) begin
      return RESP_NOMATCH;
    end
    if (win == wb_bus_pkg::N_SLAVES - 1) begin
      return RESP_TIMEOUT;
    end
    data = shadow[win][word_of(adr, win)];
    return RESP_ACK;
  endfunction

  task automatic check_response();
    string name;
    int win;
    name = test_name(req_test);
    n_resp++;
    pending = 1'b0;
    if (ack_i != (exp_kind == RESP_ACK)) begin
      value_errs++;
      $display("CHECK FAILED %s response to %08h: expected %s, actual %s", name, req_adr,
               (exp_kind == RESP_ACK) ? "ack" : "err", ack_i ? "ack" : "err");
    end else if (ack_i && !req_we && rdat_i !== exp_data) begin
      value_errs++;
      $display("CHECK FAILED %s read %08h: expected %08h, actual %08h", name, req_adr,
               exp_data, rdat_i);
    end else if (exp_kind == RESP_TIMEOUT && lat < wb_bus_pkg::TIMEOUT_CYCLES) begin
      value_errs++;
      $display("CHECK FAILED %s err latency: expected >= %0d, actual %0d", name,
               wb_bus_pkg::TIMEOUT_CYCLES, lat);
    end else if (exp_kind == RESP_NOMATCH && lat >= wb_bus_pkg::TIMEOUT_CYCLES) begin
      // decode err must not wait for the watchdog
      value_errs++;
      $display("CHECK FAILED %s err latency: expected < %0d, actual %0d", name,
               wb_bus_pkg::TIMEOUT_CYCLES, lat);
    end
    // bank follows accepted writes only
    if (ack_i && req_we && exp_kind == RESP_ACK) begin
      win = window_of(req_adr);
      shadow[win][word_of(req_adr, win)] =
        merge_bytes(shadow[win][word_of(req_adr, win)], req_dat, req_sel);
    end
  endtask

  // sampled on the rising edge with inputs settled since the falling one
  always @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      pending = 1'b0;
    end else begin
      if (pending) begin
        lat++;
      end
      if (ack_i && err_i) begin
        proto_errs++;
        $display("ERROR: ack and err raised together for request to %08h", req_adr);
      end
      if ((ack_i || err_i) && !pending) begin
        proto_errs++;
        $display("ERROR: response at %0t with no request outstanding", $time);
      end else if (ack_i || err_i) begin
        check_response();
      end
      // new request
      if (cyc_i && stb_i && !pending) begin
        req_we   = we_i;
        req_sel  = sel_i;
        req_adr  = adr_i;
        req_dat  = dat_i;
        req_test = test_id_i;
        exp_kind = expect_response(adr_i, exp_data);
        lat      = 0;
        pending  = 1'b1;
        n_req++;
      end
      if (done_i && !reported) begin
        reported = 1'b1;
        if (pending) begin
          proto_errs++;
          $display("ERROR: request to %08h was never answered", req_adr);
        end
        $display("checker: %0d requests, %0d responses, %0d value errors, %0d protocol errors",
                 n_req, n_resp, value_errs, proto_errs);
      end
    end
  end

endmodule

//--- tb/wb_subsystem_tb.sv
`timescale 1ns/1ps

module wb_subsystem_tb;

  // stimulus constants
  localparam logic [31:0] SEED = 32'hf2cbe61a;
  localparam int N_DIRECTED = 31;
  localparam int N_RANDOM = 60;
  // worst request is a reserved-window timeout plus pipeline and idle slack
  localparam int CYCLE_LIMIT =
    (N_DIRECTED + N_RANDOM) * (wb_bus_pkg::TIMEOUT_CYCLES + 16) + 100;

  logic wb_clk_i;
  logic wb_rst_i;
  logic wbm_cyc_i;
  logic wbm_stb_i;
  logic wbm_we_i;
  wb_bus_pkg::wb_sel_t  wbm_sel_i;
  wb_bus_pkg::wb_addr_t wbm_adr_i;
  wb_bus_pkg::wb_data_t wbm_dat_i;
  wb_bus_pkg::wb_data_t wbm_dat_o;
  logic wbm_ack_o;
  logic wbm_err_o;
  logic [2:0] test_id;
  logic done;
  int errors;
  int cycles;
  logic [31:0] lfsr;
  // words holding a known value, one bit per word of each bank
  logic [wb_bus_pkg::REG_WORDS-1:0] written [wb_bus_pkg::N_DEVICES];

  wb_subsystem_top wb_subsystem_top_i (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbm_cyc_i (wbm_cyc_i),
    .wbm_stb_i (wbm_stb_i),
    .wbm_we_i  (wbm_we_i),
    .wbm_sel_i (wbm_sel_i),
    .wbm_adr_i (wbm_adr_i),
    .wbm_dat_i (wbm_dat_i),
    .wbm_dat_o (wbm_dat_o),
    .wbm_ack_o (wbm_ack_o),
    .wbm_err_o (wbm_err_o)
  );

  wb_subsystem_checker u_checker (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .cyc_i     (wbm_cyc_i),
    .stb_i     (wbm_stb_i),
    .we_i      (wbm_we_i),
    .sel_i     (wbm_sel_i),
    .adr_i     (wbm_adr_i),
    .dat_i     (wbm_dat_i),
    .test_id_i (test_id),
    .done_i    (done),
    .ack_i     (wbm_ack_o),
    .err_i     (wbm_err_o),
    .rdat_i    (wbm_dat_o),
    .errors_o  (errors)
  );

  // 100 ns period
  always #50 wb_clk_i = ~wb_clk_i;

  // run limit
  always @(posedge wb_clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: no end of test after %0d cycles, DUT stopped answering", CYCLE_LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // classic cycle held until ack or err, then one idle cycle
  task automatic bus_cycle(input logic [2:0] id, input logic we, input wb_bus_pkg::wb_sel_t sel,
                           input wb_bus_pkg::wb_addr_t adr, input wb_bus_pkg::wb_data_t dat);
    @(negedge wb_clk_i);
    test_id   = id;
    wbm_we_i  = we;
    wbm_sel_i = sel;
    wbm_adr_i = adr;
    wbm_dat_i = dat;
    wbm_cyc_i = 1'b1;
    wbm_stb_i = 1'b1;
    do begin
      @(negedge wb_clk_i);
    end while (!(wbm_ack_o || wbm_err_o));
    wbm_cyc_i = 1'b0;
    wbm_stb_i = 1'b0;
  endtask

  // word idx of bank win
  task automatic bank_access(input logic [2:0] id, input logic [1:0] win, input logic [5:0] idx,
                             input logic we, input wb_bus_pkg::wb_sel_t sel,
                             input wb_bus_pkg::wb_data_t dat);
    if (we) begin
      written[win][idx] = 1'b1;
    end
    bus_cycle(id, we, sel, wb_bus_pkg::SLAVE_BASE[win] + {24'h0, idx, 2'b00}, dat);
  endtask

  initial begin
    logic [31:0] pick;
    logic [31:0] r;
    logic [31:0] wr;
    logic [31:0] sel;
    logic [31:0] dat;
    logic [1:0] win;
    logic [5:0] idx;
    wb_clk_i  = 1'b0;
    wb_rst_i  = 1'b1;
    wbm_cyc_i = 1'b0;
    wbm_stb_i = 1'b0;
    wbm_we_i  = 1'b0;
    wbm_sel_i = '0;
    wbm_adr_i = '0;
    wbm_dat_i = '0;
    test_id   = 3'd0;
    done      = 1'b0;
    cycles    = 0;
    lfsr      = SEED;
    for (int s = 0; s < wb_bus_pkg::N_DEVICES; s++) begin
      written[s] = '0;
    end
    repeat (16) @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    wb_rst_i = 1'b0;

    // full words at both ends of each bank, local address from base subtraction
    for (int s = 0; s < wb_bus_pkg::N_DEVICES; s++) begin
      take_bits(32, dat);
      bank_access(3'd1, s[1:0], 6'd5, 1'b1, 4'hf, dat);
      take_bits(32, dat);
      bank_access(3'd1, s[1:0], 6'd63, 1'b1, 4'hf, dat);
      bank_access(3'd1, s[1:0], 6'd5, 1'b0, 4'hf, '0);
      bank_access(3'd1, s[1:0], 6'd63, 1'b0, 4'hf, '0);
    end

    // byte lanes merge with the old word
    for (int s = 0; s < wb_bus_pkg::N_DEVICES; s++) begin
      take_bits(32, dat);
      bank_access(3'd2, s[1:0], 6'd5, 1'b1, 4'b0101, dat);
      bank_access(3'd2, s[1:0], 6'd5, 1'b0, 4'hf, '0);
      take_bits(32, dat);
      bank_access(3'd2, s[1:0], 6'd63, 1'b1, 4'b1000, dat);
      bank_access(3'd2, s[1:0], 6'd63, 1'b0, 4'hf, '0);
    end

    // just past a window, low bits alias word 5
    take_bits(32, dat);
    bus_cycle(3'd3, 1'b1, 4'hf, 32'h0000_0114, dat);
    bank_access(3'd3, 2'd0, 6'd5, 1'b0, 4'hf, '0);
    take_bits(32, dat);
    bus_cycle(3'd3, 1'b1, 4'hf, 32'h0000_1114, dat);
    bank_access(3'd3, 2'd1, 6'd5, 1'b0, 4'hf, '0);
    bus_cycle(3'd3, 1'b0, 4'hf, 32'h8000_0000, '0);

    // reserved window, only the watchdog answers
    take_bits(32, dat);
    bus_cycle(3'd4, 1'b1, 4'hf, 32'h0000_3010, dat);
    bus_cycle(3'd4, 1'b0, 4'hf, 32'h0000_30fc, '0);

    // random mix over all windows and unmapped space
    for (int n = 0; n < N_RANDOM; n++) begin
      take_bits(3, pick);
      take_bits(6, r);
      idx = r[5:0];
      take_bits(1, wr);
      take_bits(4, sel);
      take_bits(32, dat);
      if (pick < 32'd6) begin
        win = 2'(pick % 32'd3);
        // first touch of a word writes all lanes
        if (!written[win][idx]) begin
          wr  = 32'd1;
          sel = 32'hf;
        end
        bank_access(3'd5, win, idx, wr[0], sel[3:0], dat);
      end else if (pick == 32'd6) begin
        bus_cycle(3'd5, wr[0], sel[3:0],
                  wb_bus_pkg::SLAVE_BASE[wb_bus_pkg::N_SLAVES-1] + {24'h0, idx, 2'b00}, dat);
      end else begin
        bus_cycle(3'd5, wr[0], sel[3:0], 32'h0000_0800 + {24'h0, idx, 2'b00}, dat);
      end
    end

    // let the checker close out
    done = 1'b1;
    @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
